// File: Makefile
# Verilator build and run of the mips_cpu_bus testbench

VERILATOR   ?= verilator
TOP         ?= mips_cpu_bus_tb
FILE_LIST   ?= sources.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
PASS_STRING ?= TESTS PASSED
VFLAGS      ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_STRING)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/mips_cpu_alu.sv
`timescale 1ns/1ps

module mips_cpu_alu
  import mips_isa_pkg::*, mips_ctrl_pkg::*;
(
  input  alu_func_e  alu_func,
  input  word_t      a,
  input  word_t      b,
  input  logic [4:0] shamt,
  output word_t      result,
  output logic       condition
);

  always_comb begin
    case (alu_func)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      // unsigned compare, result is 0 or 1
      ALU_SLTU: result = {31'd0, (a < b)};
      // shifts act on the rt operand
      ALU_SLL:  result = b << shamt;
      ALU_SRL:  result = b >> shamt;
      ALU_LUI:  result = {b[15:0], 16'h0000};
      default:  result = a + b;
    endcase
  end

  // beq condition, bne takes the inverse
  assign condition = (a == b);

endmodule

// File: hdl/mips_cpu_bus.sv
`timescale 1ns/1ps

module mips_cpu_bus
  import mips_isa_pkg::*, mips_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  output logic       active,
  output word_t      register_v0,
  output word_t      address,
  output logic       write,
  output logic       read,
  input  logic       waitrequest,
  output word_t      writedata,
  output logic [3:0] byteenable,
  input  word_t      readdata
);

  function automatic word_t byte_swap(input word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  word_t pc, ir, reg_a, reg_b, alu_out, mdr;
  word_t branch_target;
  logic  branch_flag;

  word_t readdata_swapped;
  word_t rf_data_1, rf_data_2, rf_write_data;
  word_t alu_a, alu_b, alu_result;
  word_t sext_imm, zext_imm, jump_target, pc_next;
  logic  condition, stall, pc_is_zero;

  opcode_t   opcode;
  funct_t    funct;
  reg_addr_t rs, rt, rd, write_reg;
  imm_t      imm;
  logic [4:0] shamt;

  logic       pc_write, ir_write, iord, branch_latch, branch_taken;
  logic       reg_write, mem_to_reg, alu_out_en;
  pc_src_e    pc_src;
  reg_dst_e   reg_dst;
  alu_a_sel_e alu_a_sel;
  alu_b_sel_e alu_b_sel;
  alu_func_e  alu_func;

  // instruction fields
  assign opcode = ir[31:26];
  assign rs     = ir[25:21];
  assign rt     = ir[20:16];
  assign rd     = ir[15:11];
  assign shamt  = ir[10:6];
  assign funct  = ir[5:0];
  assign imm    = ir[15:0];

  assign sext_imm    = {{16{imm[15]}}, imm};
  assign zext_imm    = {16'h0000, imm};
  // pc already points at the delay slot here
  assign jump_target = {pc[31:28], ir[25:0], 2'b00};

  assign readdata_swapped = byte_swap(readdata);
  assign writedata        = byte_swap(reg_b);
  assign address          = iord ? alu_out : pc;

  assign stall      = (read || write) && waitrequest;
  assign pc_is_zero = (pc == '0);

  assign alu_a = (alu_a_sel == ALU_A_REG) ? reg_a : pc;

  always_comb begin
    case (alu_b_sel)
      ALU_B_REG:      alu_b = reg_b;
      ALU_B_FOUR:     alu_b = 32'd4;
      ALU_B_SEXT:     alu_b = sext_imm;
      ALU_B_SEXT_SH2: alu_b = {sext_imm[29:0], 2'b00};
      ALU_B_ZEXT:     alu_b = zext_imm;
      default:        alu_b = reg_b;
    endcase
  end

  always_comb begin
    case (pc_src)
      PC_SRC_ALU:     pc_next = alu_result;
      PC_SRC_ALU_OUT: pc_next = alu_out;
      PC_SRC_JUMP:    pc_next = jump_target;
      PC_SRC_REG_A:   pc_next = reg_a;
      default:        pc_next = alu_result;
    endcase
  end

  assign write_reg     = (reg_dst == REG_DST_RD) ? rd : rt;
  assign rf_write_data = mem_to_reg ? mdr : alu_out;

  // pc and the delay-slot flag
  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= RESET_VECTOR;
      branch_flag <= 1'b0;
    end else begin
      if (pc_write) begin
        pc <= branch_flag ? branch_target : pc_next;
      end
      if (branch_latch) begin
        branch_flag <= branch_taken;
      end else if (pc_write) begin
        branch_flag <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ir_write) begin
      ir <= readdata_swapped;
    end
    if (!stall) begin
      reg_a <= rf_data_1;
      reg_b <= rf_data_2;
    end
    if (alu_out_en) begin
      alu_out <= alu_result;
    end
    if (read && iord && !waitrequest) begin
      mdr <= readdata_swapped;
    end
    if (branch_latch) begin
      branch_target <= pc_next;
    end
  end

  mips_cpu_controller u_controller (
    .clk          (clk),
    .reset        (reset),
    .opcode       (opcode),
    .funct        (funct),
    .waitrequest  (waitrequest),
    .condition    (condition),
    .pc_is_zero   (pc_is_zero),
    .read         (read),
    .write        (write),
    .byteenable   (byteenable),
    .pc_write     (pc_write),
    .ir_write     (ir_write),
    .iord         (iord),
    .pc_src       (pc_src),
    .branch_latch (branch_latch),
    .branch_taken (branch_taken),
    .reg_write    (reg_write),
    .reg_dst      (reg_dst),
    .mem_to_reg   (mem_to_reg),
    .alu_a_sel    (alu_a_sel),
    .alu_b_sel    (alu_b_sel),
    .alu_func     (alu_func),
    .alu_out_en   (alu_out_en),
    .active       (active)
  );

  mips_cpu_register_file u_register_file (
    .clk          (clk),
    .reset        (reset),
    .write_enable (reg_write),
    .read_reg_1   (rs),
    .read_reg_2   (rt),
    .write_reg    (write_reg),
    .write_data   (rf_write_data),
    .read_data_1  (rf_data_1),
    .read_data_2  (rf_data_2),
    .read_data_v0 (register_v0)
  );

  mips_cpu_alu u_alu (
    .alu_func  (alu_func),
    .a         (alu_a),
    .b         (alu_b),
    .shamt     (shamt),
    .result    (alu_result),
    .condition (condition)
  );

  // avalon: address held until the slave accepts
  a_address_stable: assert property (
    @(posedge clk) disable iff (reset)
    (read || write) && waitrequest |=> $stable(address)
  );

endmodule

// File: hdl/mips_cpu_controller.sv
`timescale 1ns/1ps

module mips_cpu_controller
  import mips_isa_pkg::*, mips_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  opcode_t    opcode,
  input  funct_t     funct,
  input  logic       waitrequest,
  input  logic       condition,
  input  logic       pc_is_zero,
  output logic       read,
  output logic       write,
  output logic [3:0] byteenable,
  output logic       pc_write,
  output logic       ir_write,
  output logic       iord,
  output pc_src_e    pc_src,
  output logic       branch_latch,
  output logic       branch_taken,
  output logic       reg_write,
  output reg_dst_e   reg_dst,
  output logic       mem_to_reg,
  output alu_a_sel_e alu_a_sel,
  output alu_b_sel_e alu_b_sel,
  output alu_func_e  alu_func,
  output logic       alu_out_en,
  output logic       active
);

  cpu_state_e state, state_next;
  alu_func_e  rtype_func;
  logic       instr_done;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_FETCH;
    end else begin
      state <= state_next;
    end
  end

  assign active     = (state != ST_HALT);
  assign byteenable = (read || write) ? BYTE_EN_ALL : 4'b0000;

  // funct to alu operation
  always_comb begin
    case (funct)
      FN_SUBU: rtype_func = ALU_SUB;
      FN_AND:  rtype_func = ALU_AND;
      FN_OR:   rtype_func = ALU_OR;
      FN_XOR:  rtype_func = ALU_XOR;
      FN_SLTU: rtype_func = ALU_SLTU;
      FN_SLL:  rtype_func = ALU_SLL;
      FN_SRL:  rtype_func = ALU_SRL;
      default: rtype_func = ALU_ADD;
    endcase
  end

  always_comb begin
    state_next   = state;
    instr_done   = 1'b0;
    read         = 1'b0;
    write        = 1'b0;
    pc_write     = 1'b0;
    ir_write     = 1'b0;
    iord         = 1'b0;
    pc_src       = PC_SRC_ALU;
    branch_latch = 1'b0;
    branch_taken = 1'b0;
    reg_write    = 1'b0;
    reg_dst      = REG_DST_RT;
    mem_to_reg   = 1'b0;
    alu_a_sel    = ALU_A_PC;
    alu_b_sel    = ALU_B_FOUR;
    alu_func     = ALU_ADD;
    alu_out_en   = 1'b0;

    case (state)
      ST_FETCH: begin
        // pc + 4 through the alu
        read = 1'b1;
        if (!waitrequest) begin
          ir_write   = 1'b1;
          pc_write   = 1'b1;
          state_next = ST_DECODE;
        end
      end
      ST_DECODE: begin
        // branch target into alu_out
        alu_b_sel  = ALU_B_SEXT_SH2;
        alu_out_en = 1'b1;
        state_next = ST_EXEC;
      end
      ST_EXEC: begin
        alu_a_sel  = ALU_A_REG;
        alu_out_en = 1'b1;
        state_next = ST_WB;
        case (opcode)
          OP_RTYPE: begin
            alu_b_sel = ALU_B_REG;
            alu_func  = rtype_func;
            if (funct == FN_JR) begin
              alu_out_en   = 1'b0;
              pc_src       = PC_SRC_REG_A;
              branch_latch = 1'b1;
              branch_taken = 1'b1;
              instr_done   = 1'b1;
            end
          end
          OP_ADDIU: alu_b_sel = ALU_B_SEXT;
          OP_ORI: begin
            alu_b_sel = ALU_B_ZEXT;
            alu_func  = ALU_OR;
          end
          OP_LUI: begin
            alu_b_sel = ALU_B_ZEXT;
            alu_func  = ALU_LUI;
          end
          OP_LW, OP_SW: begin
            alu_b_sel  = ALU_B_SEXT;
            state_next = ST_MEM;
          end
          OP_BEQ, OP_BNE: begin
            // compare a and b, target was computed in decode
            alu_b_sel    = ALU_B_REG;
            alu_func     = ALU_SUB;
            alu_out_en   = 1'b0;
            pc_src       = PC_SRC_ALU_OUT;
            branch_latch = 1'b1;
            branch_taken = (opcode == OP_BEQ) ? condition : !condition;
            instr_done   = 1'b1;
          end
          OP_J: begin
            alu_out_en   = 1'b0;
            pc_src       = PC_SRC_JUMP;
            branch_latch = 1'b1;
            branch_taken = 1'b1;
            instr_done   = 1'b1;
          end
          default: begin
            // unknown opcode retires as a nop
            alu_out_en = 1'b0;
            instr_done = 1'b1;
          end
        endcase
      end
      ST_MEM: begin
        iord = 1'b1;
        if (opcode == OP_SW) begin
          write = 1'b1;
          if (!waitrequest) begin
            instr_done = 1'b1;
          end
        end else begin
          read = 1'b1;
          if (!waitrequest) begin
            state_next = ST_WB;
          end
        end
      end
      ST_WB: begin
        reg_write  = 1'b1;
        reg_dst    = (opcode == OP_RTYPE) ? REG_DST_RD : REG_DST_RT;
        mem_to_reg = (opcode == OP_LW);
        instr_done = 1'b1;
      end
      default: state_next = ST_HALT;
    endcase

    if (instr_done) begin
      state_next = pc_is_zero ? ST_HALT : ST_FETCH;
    end
  end

  a_no_read_and_write: assert property (
    @(posedge clk) disable iff (reset)
    !(read && write)
  );

  a_halt_quiet: assert property (
    @(posedge clk) disable iff (reset)
    (state == ST_HALT) |=> (state == ST_HALT) && !read && !write
  );

endmodule

// File: hdl/mips_cpu_register_file.sv
`timescale 1ns/1ps

module mips_cpu_register_file
  import mips_isa_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      write_enable,
  input  reg_addr_t read_reg_1,
  input  reg_addr_t read_reg_2,
  input  reg_addr_t write_reg,
  input  word_t     write_data,
  output word_t     read_data_1,
  output word_t     read_data_2,
  output word_t     read_data_v0
);

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && write_reg != '0) begin
      // $zero stays zero
      regs[write_reg] <= write_data;
    end
  end

  assign read_data_1  = regs[read_reg_1];
  assign read_data_2  = regs[read_reg_2];
  assign read_data_v0 = regs[REG_V0];

  a_zero_reg_1: assert property (
    @(posedge clk) disable iff (reset)
    (read_reg_1 == '0) |-> (read_data_1 == '0)
  );

  a_zero_reg_2: assert property (
    @(posedge clk) disable iff (reset)
    (read_reg_2 == '0) |-> (read_data_2 == '0)
  );

endmodule

// File: hdl/mips_ctrl_pkg.sv
package mips_ctrl_pkg;

  typedef enum logic [2:0] {
    ST_HALT,
    ST_FETCH,
    ST_DECODE,
    ST_EXEC,
    ST_MEM,
    ST_WB
  } cpu_state_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_LUI
  } alu_func_e;

  typedef enum logic {
    ALU_A_PC,
    ALU_A_REG
  } alu_a_sel_e;

  typedef enum logic [2:0] {
    ALU_B_REG,
    ALU_B_FOUR,
    ALU_B_SEXT,
    ALU_B_SEXT_SH2,
    ALU_B_ZEXT
  } alu_b_sel_e;

  typedef enum logic [1:0] {
    PC_SRC_ALU,
    PC_SRC_ALU_OUT,
    PC_SRC_JUMP,
    PC_SRC_REG_A
  } pc_src_e;

  typedef enum logic {
    REG_DST_RT,
    REG_DST_RD
  } reg_dst_e;

  // every bus access is a full word
  localparam logic [3:0] BYTE_EN_ALL = 4'b1111;

endpackage

// File: hdl/mips_isa_pkg.sv
package mips_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [15:0] imm_t;

  // major opcodes
  localparam opcode_t OP_RTYPE = 6'h00;
  localparam opcode_t OP_J     = 6'h02;
  localparam opcode_t OP_BEQ   = 6'h04;
  localparam opcode_t OP_BNE   = 6'h05;
  localparam opcode_t OP_ADDIU = 6'h09;
  localparam opcode_t OP_ORI   = 6'h0d;
  localparam opcode_t OP_LUI   = 6'h0f;
  localparam opcode_t OP_LW    = 6'h23;
  localparam opcode_t OP_SW    = 6'h2b;

  // r-type function codes
  localparam funct_t FN_SLL  = 6'h00;
  localparam funct_t FN_SRL  = 6'h02;
  localparam funct_t FN_JR   = 6'h08;
  localparam funct_t FN_ADDU = 6'h21;
  localparam funct_t FN_SUBU = 6'h23;
  localparam funct_t FN_AND  = 6'h24;
  localparam funct_t FN_OR   = 6'h25;
  localparam funct_t FN_XOR  = 6'h26;
  localparam funct_t FN_SLTU = 6'h2b;

  localparam word_t RESET_VECTOR = 32'hbfc0_0000;

  localparam reg_addr_t REG_V0 = 5'd2;
  // link register, kept for future jal/jalr
  localparam reg_addr_t REG_RA = 5'd31;

endpackage

// File: sources.f
hdl/mips_isa_pkg.sv
hdl/mips_ctrl_pkg.sv
hdl/mips_cpu_alu.sv
hdl/mips_cpu_register_file.sv
hdl/mips_cpu_controller.sv
hdl/mips_cpu_bus.sv
test/avalon_ram_model.sv
test/mips_cpu_bus_tb.sv

// File: test/avalon_ram_model.sv
`timescale 1ns/1ps

module avalon_ram_model
  import mips_isa_pkg::*;
#(
  parameter int SEED = 1
) (
  input  logic       clk,
  input  word_t      address,
  input  logic       read,
  input  logic       write,
  input  word_t      writedata,
  input  logic [3:0] byteenable,
  output logic       waitrequest,
  output word_t      readdata
);

  // 4 KiB window, higher address bits alias
  word_t mem [1024];

  function automatic int word_index(input word_t addr);
    return int'(addr[11:2]);
  endfunction

  task automatic clear_memory();
    for (int i = 0; i < 1024; i++) begin
      mem[i] = '0;
    end
  endtask

  task automatic load_word(input word_t addr, input word_t data);
    mem[word_index(addr)] = data;
  endtask

  function automatic word_t peek_word(input word_t addr);
    return mem[word_index(addr)];
  endfunction

  initial begin : slave
    int         wait_cnt;
    logic       busy;
    logic       done;
    logic       wr;
    logic [3:0] be;
    word_t      addr;
    word_t      data;
    wait_cnt    = 0;
    waitrequest = 1'b0;
    readdata    = '0;
    void'($urandom(SEED));
    forever begin
      @(posedge clk);
      // access as seen at the edge
      busy = read || write;
      done = busy && !waitrequest;
      wr   = write;
      be   = byteenable;
      addr = address;
      data = writedata;
      #1;
      if (done && wr) begin
        for (int b = 0; b < 4; b++) begin
          if (be[b]) begin
            mem[word_index(addr)][8*b +: 8] = data[8*b +: 8];
          end
        end
      end
      if (done) begin
        // stall length of the next access
        wait_cnt = $urandom_range(3, 0);
      end else if (busy) begin
        wait_cnt = wait_cnt - 1;
      end
      waitrequest = (wait_cnt != 0);
      readdata    = mem[word_index(address)];
    end
  end

endmodule

// File: test/mips_cpu_bus_tb.sv
`timescale 1ns/1ps

module mips_cpu_bus_tb
  import mips_isa_pkg::*;
();

  localparam time   CLK_PERIOD  = 40ns;
  localparam int    RANDOM_SEED = 82068;
  // 5 tests x 30 instructions x (5 states + 2 accesses x 3 stalls), rounded up
  localparam int    MAX_CYCLES  = 4000;
  localparam word_t DATA_BASE   = 32'h0000_0400;

  logic       clk, reset, active, write, read, waitrequest;
  logic [3:0] byteenable;
  word_t      register_v0, address, writedata, readdata;
  int         cycle_count;
  int         prog_len;

  mips_cpu_bus uut (
    .clk         (clk),
    .reset       (reset),
    .active      (active),
    .register_v0 (register_v0),
    .address     (address),
    .write       (write),
    .read        (read),
    .waitrequest (waitrequest),
    .writedata   (writedata),
    .byteenable  (byteenable),
    .readdata    (readdata)
  );

  avalon_ram_model #(.SEED(RANDOM_SEED)) ram (
    .clk         (clk),
    .address     (address),
    .read        (read),
    .write       (write),
    .writedata   (writedata),
    .byteenable  (byteenable),
    .waitrequest (waitrequest),
    .readdata    (readdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count >= MAX_CYCLES) begin
        $display("timeout: the core did not halt within %0d cycles", MAX_CYCLES);
        $display("TESTS FAILED");
        $fatal(1, "simulation timeout");
      end
    end
  end

  task automatic check_value(input string what, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "check failed");
    end
  endtask

  // memory holds big-endian words
  function automatic word_t to_big_endian(input word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  function automatic word_t encode_rtype(input int rs, input int rt, input int rd,
                                         input int shamt, input funct_t fn);
    return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), fn};
  endfunction

  function automatic word_t encode_itype(input opcode_t op, input int rs, input int rt,
                                         input int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  // target is an instruction index in the program
  function automatic word_t encode_jump(input int index);
    word_t target;
    target = RESET_VECTOR + 32'(index * 4);
    return {OP_J, target[27:2]};
  endfunction

  task automatic new_program();
    ram.clear_memory();
    prog_len = 0;
  endtask

  task automatic put_instr(input word_t instr);
    ram.load_word(RESET_VECTOR + 32'(prog_len * 4), to_big_endian(instr));
    prog_len++;
  endtask

  // jr $0 and its delay slot
  task automatic put_halt(input word_t delay_slot);
    put_instr(encode_rtype(0, 0, 0, 0, FN_JR));
    put_instr(delay_slot);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  task automatic wait_for_halt();
    @(negedge clk);
    while (active) begin
      @(negedge clk);
    end
  endtask

  task automatic test_reset();
    new_program();
    put_halt(32'h0000_0000);
    apply_reset();
    @(negedge clk);
    check_value("active after reset", 32'(active), 32'd1);
    check_value("write after reset", 32'(write), 32'd0);
    check_value("read after reset", 32'(read), 32'd1);
    check_value("first fetch address", address, RESET_VECTOR);
    check_value("byteenable on first fetch", 32'(byteenable), 32'h0000_000f);
    wait_for_halt();
  endtask

  task automatic test_alu();
    word_t r8, r9, r10, r11, r12, r13, r14, r15, r16, r17, r18;
    new_program();
    put_instr(encode_itype(OP_ADDIU, 0, 8, 'h1234));
    put_instr(encode_itype(OP_LUI, 0, 9, 'hdead));
    put_instr(encode_itype(OP_ORI, 9, 9, 'hbeef));
    put_instr(encode_rtype(8, 9, 10, 0, FN_ADDU));
    put_instr(encode_rtype(9, 8, 11, 0, FN_SUBU));
    put_instr(encode_rtype(10, 11, 12, 0, FN_AND));
    put_instr(encode_rtype(12, 8, 13, 0, FN_OR));
    put_instr(encode_rtype(13, 9, 14, 0, FN_XOR));
    put_instr(encode_rtype(8, 9, 15, 0, FN_SLTU));
    put_instr(encode_rtype(0, 14, 16, 4, FN_SLL));
    put_instr(encode_rtype(0, 16, 17, 3, FN_SRL));
    put_instr(encode_itype(OP_ADDIU, 0, 18, -5));
    put_instr(encode_rtype(17, 15, 2, 0, FN_ADDU));
    put_instr(encode_rtype(2, 18, 2, 0, FN_ADDU));
    put_halt(32'h0000_0000);
    apply_reset();
    wait_for_halt();
    r8  = 32'h0000_1234;
    r9  = (32'h0000_dead << 16) | 32'h0000_beef;
    r10 = r8 + r9;
    r11 = r9 - r8;
    r12 = r10 & r11;
    r13 = r12 | r8;
    r14 = r13 ^ r9;
    r15 = (r8 < r9) ? 32'd1 : 32'd0;
    r16 = r14 << 4;
    r17 = r16 >> 3;
    // addiu sign-extends its immediate
    r18 = 32'hffff_fffb;
    check_value("$v0 after alu program", register_v0, r17 + r15 + r18);
  endtask

  task automatic test_memory();
    word_t stored;
    new_program();
    put_instr(encode_itype(OP_LUI, 0, 8, 'h1357));
    put_instr(encode_itype(OP_ORI, 8, 8, 'h9bdf));
    put_instr(encode_itype(OP_ADDIU, 0, 9, int'(DATA_BASE)));
    put_instr(encode_itype(OP_SW, 9, 8, 8));
    put_instr(encode_itype(OP_LW, 9, 2, 8));
    put_halt(32'h0000_0000);
    apply_reset();
    wait_for_halt();
    stored = (32'h0000_1357 << 16) | 32'h0000_9bdf;
    check_value("stored memory word", ram.peek_word(DATA_BASE + 32'd8), to_big_endian(stored));
    check_value("$v0 after load", register_v0, stored);
  endtask

  task automatic test_branches();
    word_t expected;
    new_program();
    put_instr(encode_itype(OP_ADDIU, 0, 2, 1));
    put_instr(encode_itype(OP_ADDIU, 0, 8, 5));
    put_instr(encode_itype(OP_ADDIU, 0, 9, 5));
    // index 3, taken to index 7
    put_instr(encode_itype(OP_BEQ, 8, 9, 3));
    put_instr(encode_itype(OP_ADDIU, 2, 2, 2));
    put_instr(encode_itype(OP_ADDIU, 2, 2, 100));
    put_instr(encode_itype(OP_ADDIU, 2, 2, 200));
    // not taken, would land on index 12
    put_instr(encode_itype(OP_BNE, 8, 9, 4));
    put_instr(encode_itype(OP_ADDIU, 2, 2, 4));
    put_instr(encode_itype(OP_ADDIU, 2, 2, 8));
    put_instr(encode_jump(13));
    put_instr(encode_itype(OP_ADDIU, 2, 2, 16));
    put_instr(encode_itype(OP_ADDIU, 2, 2, 1000));
    put_instr(encode_itype(OP_ADDIU, 2, 2, 32));
    put_halt(32'h0000_0000);
    apply_reset();
    wait_for_halt();
    // delay slots run, 100, 200 and 1000 are skipped
    expected = 32'(1 + 2 + 4 + 8 + 16 + 32);
    check_value("$v0 after branches", register_v0, expected);
  endtask

  task automatic test_halt();
    new_program();
    put_instr(encode_itype(OP_ADDIU, 0, 2, 7));
    put_halt(encode_itype(OP_ADDIU, 2, 2, 'h30));
    put_instr(encode_itype(OP_ADDIU, 2, 2, 'h100));
    apply_reset();
    wait_for_halt();
    repeat (20) begin
      @(negedge clk);
      check_value("active while halted", 32'(active), 32'd0);
      check_value("bus strobes while halted", 32'({read, write}), 32'd0);
    end
    check_value("$v0 after halt", register_v0, 32'd7 + 32'h30);
  endtask

  initial begin
    reset    = 1'b1;
    prog_len = 0;
    test_reset();
    test_alu();
    test_memory();
    test_branches();
    test_halt();
    $display("TESTS PASSED");
    $finish;
  end

endmodule
